// File: exec.f
hdl/exec_pkg.sv
hdl/alu.sv
hdl/mul_seq.sv
hdl/step_counter.sv
hdl/exec_ctrl.sv
hdl/result_stage.sv
hdl/exec_unit.sv
tests/exec_assert.sv
tests/exec_tb.sv

// File: hdl/alu.sv
// ********************
// alu: single-word logic, add/sub and shift
// operations with carry, zero, negative, overflow
// ********************
`default_nettype none

module alu (
  input  exec_pkg::func_t  func,
  input  exec_pkg::word_t  a,
  input  exec_pkg::word_t  b,
  input  logic             c_in,
  input  logic             z_chain,
  output exec_pkg::word_t  lo,
  output exec_pkg::flags_t flags
);

  exec_pkg::shamt_t          shamt;
  logic [exec_pkg::WIDTH:0]  sum;
  logic [exec_pkg::WIDTH:0]  diff;
  logic [exec_pkg::WIDTH:0]  shl_ext;
  logic [exec_pkg::WIDTH:0]  srl_ext;
  logic [exec_pkg::WIDTH:0]  sra_ext;
  logic                      a_msb;
  logic                      b_msb;
  logic                      c_out;
  logic                      v_out;

  // only the low bits of b count as shift amount
  assign shamt = b[exec_pkg::SHAMT_W-1:0];

  assign a_msb = a[exec_pkg::WIDTH-1];
  assign b_msb = b[exec_pkg::WIDTH-1];

  // one extra bit on top catches carry and borrow
  assign sum  = {1'b0, a} + {1'b0, b} + {{exec_pkg::WIDTH{1'b0}}, c_in};
  assign diff = {1'b0, a} - {1'b0, b};

  // the extra bit holds the last bit shifted out, zero for a shift by 0
  assign shl_ext = {1'b0, a} << shamt;
  assign srl_ext = {a, 1'b0} >> shamt;
  assign sra_ext = $signed({a, 1'b0}) >>> shamt;

  always_comb begin
    lo    = a;
    c_out = c_in;
    v_out = 1'b0;
    case (func)
      exec_pkg::FUNC_AND: lo = a & b;
      exec_pkg::FUNC_OR:  lo = a | b;
      exec_pkg::FUNC_XOR: lo = a ^ b;
      exec_pkg::FUNC_ADD: begin
        lo    = sum[exec_pkg::WIDTH-1:0];
        c_out = sum[exec_pkg::WIDTH];
        v_out = (a_msb == b_msb) && (sum[exec_pkg::WIDTH-1] != a_msb);
      end
      exec_pkg::FUNC_SUB: begin
        lo    = diff[exec_pkg::WIDTH-1:0];
        c_out = diff[exec_pkg::WIDTH];
        v_out = (a_msb != b_msb) && (diff[exec_pkg::WIDTH-1] != a_msb);
      end
      exec_pkg::FUNC_SHL: begin
        lo    = shl_ext[exec_pkg::WIDTH-1:0];
        c_out = shl_ext[exec_pkg::WIDTH];
        v_out = shl_ext[exec_pkg::WIDTH-1] ^ shl_ext[exec_pkg::WIDTH];
      end
      exec_pkg::FUNC_SRA: begin
        lo    = sra_ext[exec_pkg::WIDTH:1];
        c_out = sra_ext[0];
        v_out = sra_ext[exec_pkg::WIDTH] ^ sra_ext[0];
      end
      exec_pkg::FUNC_SRL: begin
        lo    = srl_ext[exec_pkg::WIDTH:1];
        c_out = srl_ext[0];
        v_out = srl_ext[exec_pkg::WIDTH] ^ srl_ext[0];
      end
      // pass-through codes, multiply results come from mul_seq
      default: lo = a;
    endcase
  end

  assign flags.c = c_out;
  assign flags.z = (lo == '0) & z_chain;
  assign flags.n = lo[exec_pkg::WIDTH-1];
  assign flags.v = v_out;

endmodule

`default_nettype wire

// File: hdl/exec_ctrl.sv
// ********************
// exec_ctrl: accepts start, sequences ALU or
// multiplier, issues capture and done
// ********************
`default_nettype none

module exec_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  exec_pkg::exec_req_t req,
  input  logic                last_step,
  output exec_pkg::exec_req_t cur_req,
  output logic                busy,
  output logic                mul_start,
  output logic                step,
  output logic                capture_alu,
  output logic                capture_mul,
  output logic                done
);

  exec_pkg::ctrl_state_e state;
  logic                  accept;
  logic                  is_mul;

  assign accept = (state == exec_pkg::IDLE) && start;
  assign is_mul = (req.func == exec_pkg::FUNC_MUL) || (req.func == exec_pkg::FUNC_MULU);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= exec_pkg::IDLE;
      mul_start   <= 1'b0;
      capture_mul <= 1'b0;
    end else begin
      mul_start   <= accept && is_mul;
      // capture one edge after the final multiply step
      capture_mul <= last_step;
      case (state)
        exec_pkg::IDLE: begin
          if (start) begin
            if (is_mul) begin
              state <= exec_pkg::MUL_RUN;
            end else begin
              state <= exec_pkg::ALU_OP;
            end
          end
        end
        exec_pkg::ALU_OP: state <= exec_pkg::FINISH;
        exec_pkg::MUL_RUN: begin
          if (capture_mul) begin
            state <= exec_pkg::FINISH;
          end
        end
        exec_pkg::FINISH: state <= exec_pkg::IDLE;
        default: state <= exec_pkg::IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cur_req <= req;
    end
  end

  assign busy        = (state != exec_pkg::IDLE);
  // first MUL_RUN cycle loads, the capture cycle does not step
  assign step        = (state == exec_pkg::MUL_RUN) && !mul_start && !capture_mul;
  assign capture_alu = (state == exec_pkg::ALU_OP);
  assign done        = (state == exec_pkg::FINISH);

endmodule

`default_nettype wire

// File: hdl/exec_pkg.sv
// ********************
// execute stage package: widths, function codes,
// request/response structs and control states
// ********************
`default_nettype none

package exec_pkg;

  localparam int WIDTH   = 32;
  localparam int SHAMT_W = 5;
  localparam int FUNC_W  = 4;

  typedef logic [WIDTH-1:0]   word_t;
  typedef logic [SHAMT_W-1:0] shamt_t;
  typedef logic [FUNC_W-1:0]  func_t;

  // function codes, 10 to 15 pass operand a through
  localparam func_t FUNC_AND  = 4'h0;
  localparam func_t FUNC_OR   = 4'h1;
  localparam func_t FUNC_ADD  = 4'h2;
  localparam func_t FUNC_SUB  = 4'h3;
  localparam func_t FUNC_SHL  = 4'h4;
  localparam func_t FUNC_SRA  = 4'h5;
  localparam func_t FUNC_SRL  = 4'h6;
  localparam func_t FUNC_XOR  = 4'h7;
  localparam func_t FUNC_MUL  = 4'h8;
  localparam func_t FUNC_MULU = 4'h9;

  typedef struct packed {
    logic c;
    logic z;
    logic n;
    logic v;
  } flags_t;

  typedef struct packed {
    func_t func;
    word_t a;
    word_t b;
    logic  use_flags;
  } exec_req_t;

  typedef struct packed {
    word_t  lo;
    word_t  hi;
    flags_t flags;
  } exec_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    ALU_OP,
    MUL_RUN,
    FINISH
  } ctrl_state_e;

endpackage

`default_nettype wire

// File: hdl/exec_unit.sv
// ********************
// exec_unit: integer execute stage top level
// ********************
`default_nettype none

module exec_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                start,
  input  exec_pkg::exec_req_t req,
  output logic                busy,
  output logic                done,
  output exec_pkg::exec_rsp_t rsp
);

  exec_pkg::exec_req_t cur_req;
  exec_pkg::word_t     alu_lo;
  exec_pkg::flags_t    alu_flags;
  exec_pkg::word_t     mul_hi;
  exec_pkg::word_t     mul_lo;
  logic                last_step;
  logic                mul_start;
  logic                step;
  logic                capture_alu;
  logic                capture_mul;
  logic                c_in;
  logic                z_chain;

  exec_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start       (start),
    .req         (req),
    .last_step   (last_step),
    .cur_req     (cur_req),
    .busy        (busy),
    .mul_start   (mul_start),
    .step        (step),
    .capture_alu (capture_alu),
    .capture_mul (capture_mul),
    .done        (done)
  );

  alu u_alu (
    .func    (cur_req.func),
    .a       (cur_req.a),
    .b       (cur_req.b),
    .c_in    (c_in),
    .z_chain (z_chain),
    .lo      (alu_lo),
    .flags   (alu_flags)
  );

  mul_seq u_mul (
    .clk       (clk),
    .rst_n     (rst_n),
    .mul_start (mul_start),
    .is_signed (cur_req.func == exec_pkg::FUNC_MUL),
    .a         (cur_req.a),
    .b         (cur_req.b),
    .step      (step),
    .hi        (mul_hi),
    .lo        (mul_lo)
  );

  // counter loads together with the multiplier operands
  step_counter u_steps (
    .clk       (clk),
    .rst_n     (rst_n),
    .load      (mul_start),
    .count     (step),
    .last_step (last_step)
  );

  result_stage u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .capture_alu (capture_alu),
    .capture_mul (capture_mul),
    .use_flags   (cur_req.use_flags),
    .alu_lo      (alu_lo),
    .alu_flags   (alu_flags),
    .mul_hi      (mul_hi),
    .mul_lo      (mul_lo),
    .c_in        (c_in),
    .z_chain     (z_chain),
    .rsp         (rsp)
  );

endmodule

`default_nettype wire

// File: hdl/mul_seq.sv
// ********************
// mul_seq: shift-add multiplier, one bit per step
// ********************
`default_nettype none

module mul_seq (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            mul_start,
  input  logic            is_signed,
  input  exec_pkg::word_t a,
  input  exec_pkg::word_t b,
  input  logic            step,
  output exec_pkg::word_t hi,
  output exec_pkg::word_t lo
);

  logic [2*exec_pkg::WIDTH-1:0] mcand;
  logic [2*exec_pkg::WIDTH-1:0] acc;
  logic [2*exec_pkg::WIDTH-1:0] product;
  exec_pkg::word_t              mplier;
  exec_pkg::word_t              a_mag;
  exec_pkg::word_t              b_mag;
  logic                         neg;

  // magnitudes for signed multiply, 0x80000000 maps to itself as unsigned
  assign a_mag = (is_signed && a[exec_pkg::WIDTH-1]) ? -a : a;
  assign b_mag = (is_signed && b[exec_pkg::WIDTH-1]) ? -b : b;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc <= '0;
      neg <= 1'b0;
    end else if (mul_start) begin
      acc <= '0;
      neg <= is_signed & (a[exec_pkg::WIDTH-1] ^ b[exec_pkg::WIDTH-1]);
    end else if (step && mplier[0]) begin
      acc <= acc + mcand;
    end
  end

  always_ff @(posedge clk) begin
    if (mul_start) begin
      mcand  <= {{exec_pkg::WIDTH{1'b0}}, a_mag};
      mplier <= b_mag;
    end else if (step) begin
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

  // sign correction of the unsigned magnitude product
  assign product  = neg ? -acc : acc;
  assign hi = product[2*exec_pkg::WIDTH-1:exec_pkg::WIDTH];
  assign lo = product[exec_pkg::WIDTH-1:0];

endmodule

`default_nettype wire

// File: hdl/result_stage.sv
// ********************
// result_stage: response and flag register,
// carry-in and zero-chain sources
// ********************
`default_nettype none

module result_stage (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                capture_alu,
  input  logic                capture_mul,
  input  logic                use_flags,
  input  exec_pkg::word_t     alu_lo,
  input  exec_pkg::flags_t    alu_flags,
  input  exec_pkg::word_t     mul_hi,
  input  exec_pkg::word_t     mul_lo,
  output logic                c_in,
  output logic                z_chain,
  output exec_pkg::exec_rsp_t rsp
);

  exec_pkg::flags_t mul_flags;

  // stored flags feed the next operation when chaining
  assign c_in    = use_flags & rsp.flags.c;
  assign z_chain = ~use_flags | rsp.flags.z;

  // multiply sets no carry or overflow, z covers the whole product
  assign mul_flags.c = 1'b0;
  assign mul_flags.z = ({mul_hi, mul_lo} == '0) & z_chain;
  assign mul_flags.n = mul_lo[exec_pkg::WIDTH-1];
  assign mul_flags.v = 1'b0;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rsp <= '0;
    end else if (capture_alu) begin
      rsp.lo    <= alu_lo;
      rsp.hi    <= '0;
      rsp.flags <= alu_flags;
    end else if (capture_mul) begin
      rsp.lo    <= mul_lo;
      rsp.hi    <= mul_hi;
      rsp.flags <= mul_flags;
    end
  end

endmodule

`default_nettype wire

// File: hdl/step_counter.sv
// ********************
// step_counter: times the multiply steps
// ********************
`default_nettype none

module step_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic load,
  input  logic count,
  output logic last_step
);

  typedef logic [$clog2(exec_pkg::WIDTH)-1:0] step_t;

  step_t value;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value <= '0;
    end else if (load) begin
      value <= step_t'(exec_pkg::WIDTH - 1);
    end else if (count && (value != '0)) begin
      value <= value - 1'b1;
    end
  end

  assign last_step = count && (value == '0);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module exec_tb \
    -f exec.f -o exec_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/exec_sim)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^RESULT: PASS$"; then
  exit 0
fi

echo "pass message not found in simulation output"
exit 1

// File: tests/exec_assert.sv
// ********************
// exec_assert: start/busy/done protocol checks
// ********************
`default_nettype none

module exec_assert (
  input logic                clk,
  input logic                rst_n,
  input logic                start,
  input logic                busy,
  input logic                done,
  input exec_pkg::exec_req_t req
);

  logic accept;
  logic is_mul;
  logic pending;

  assign accept = start && !busy;
  assign is_mul = (req.func == exec_pkg::FUNC_MUL) || (req.func == exec_pkg::FUNC_MULU);

  // an accepted request waits for its done
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else if (accept) begin
      pending <= 1'b1;
    end else if (done) begin
      pending <= 1'b0;
    end
  end

  done_single: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else $error("done held for more than one cycle");

  done_busy: assert property (@(posedge clk) disable iff (!rst_n) done |-> busy)
    else $error("done without busy");

  done_started: assert property (@(posedge clk) disable iff (!rst_n) done |-> pending)
    else $error("done without an accepted start");

  alu_latency: assert property (@(posedge clk) disable iff (!rst_n)
    (accept && !is_mul) |-> ##2 done)
    else $error("non-multiply done not two edges after start");

endmodule

`default_nettype wire

// File: tests/exec_tb.sv
// ********************
// execute stage testbench with a directed table and a random phase
// ********************
`default_nettype none

module exec_tb;

  localparam int RESET_CYCLES = 8;
  localparam int N_RAND       = 200;

  typedef struct packed {
    exec_pkg::exec_req_t req;
    exec_pkg::exec_rsp_t rsp;
    logic                poke;
  } vec_t;

  logic                clk;
  logic                rst_n;
  logic                start;
  exec_pkg::exec_req_t req;
  logic                busy;
  logic                done;
  exec_pkg::exec_rsp_t rsp;

  vec_t             vecs[$];
  logic [31:0]      lfsr;
  exec_pkg::flags_t model_flags;
  int               cycles;
  int               limit;

  bind exec_unit exec_assert u_assert (
    .clk(clk), .rst_n(rst_n), .start(start), .busy(busy), .done(done), .req(req)
  );

  exec_unit DUT (
    .clk(clk), .rst_n(rst_n), .start(start), .req(req), .busy(busy), .done(done), .rsp(rsp)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      abort_run("timeout: the test did not finish within the cycle limit");
    end
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("RESULT: FAIL");
    $fatal(1);
  endtask

  task automatic check_word(input string name, input exec_pkg::word_t got,
                            input exec_pkg::word_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH %s got 0x%08h exp 0x%08h", name, got, exp));
    end
  endtask

  task automatic check_flags(input exec_pkg::flags_t got, input exec_pkg::flags_t exp);
    if (got !== exp) begin
      abort_run($sformatf("MISMATCH rsp.flags got 0x%01h exp 0x%01h", got, exp));
    end
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] galois_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output exec_pkg::word_t val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = galois_step(lfsr);
      val  = {val[30:0], lfsr[0]};
    end
  endtask

  // expected response from the stage rules and the model flag register
  function automatic exec_pkg::exec_rsp_t model_exec(input exec_pkg::exec_req_t r,
                                                     input exec_pkg::flags_t f);
    exec_pkg::exec_rsp_t res;
    logic [63:0]         prod;
    logic [32:0]         wide;
    int                  s;
    logic                cin;
    logic                zchain;
    logic                is_mul;
    cin    = r.use_flags ? f.c : 1'b0;
    zchain = r.use_flags ? f.z : 1'b1;
    s      = int'(r.b[4:0]);
    is_mul = 1'b0;
    prod   = '0;
    res    = '0;
    res.lo = r.a;
    res.flags.c = cin;
    case (r.func)
      exec_pkg::FUNC_AND: res.lo = r.a & r.b;
      exec_pkg::FUNC_OR:  res.lo = r.a | r.b;
      exec_pkg::FUNC_XOR: res.lo = r.a ^ r.b;
      exec_pkg::FUNC_ADD: begin
        wide = 33'(r.a) + 33'(r.b) + 33'(cin);
        res.lo = wide[31:0];
        res.flags.c = wide[32];
        res.flags.v = (r.a[31] == r.b[31]) && (res.lo[31] != r.a[31]);
      end
      exec_pkg::FUNC_SUB: begin
        res.lo = r.a - r.b;
        res.flags.c = (r.a < r.b);
        res.flags.v = (r.a[31] != r.b[31]) && (res.lo[31] != r.a[31]);
      end
      exec_pkg::FUNC_SHL, exec_pkg::FUNC_SRL, exec_pkg::FUNC_SRA: begin
        if (r.func == exec_pkg::FUNC_SHL) begin
          res.lo = r.a << s;
          res.flags.c = (s == 0) ? 1'b0 : r.a[32 - s];
        end else if (r.func == exec_pkg::FUNC_SRA) begin
          res.lo = $signed(r.a) >>> s;
          res.flags.c = (s == 0) ? 1'b0 : r.a[s - 1];
        end else begin
          res.lo = r.a >> s;
          res.flags.c = (s == 0) ? 1'b0 : r.a[s - 1];
        end
        res.flags.v = res.lo[31] ^ res.flags.c;
      end
      exec_pkg::FUNC_MUL, exec_pkg::FUNC_MULU: begin
        is_mul = 1'b1;
        if (r.func == exec_pkg::FUNC_MUL) begin
          prod = $signed({{32{r.a[31]}}, r.a}) * $signed({{32{r.b[31]}}, r.b});
        end else begin
          prod = {32'h0, r.a} * {32'h0, r.b};
        end
        res.lo = prod[31:0];
        res.hi = prod[63:32];
        res.flags.c = 1'b0;
      end
      default: res.lo = r.a;
    endcase
    res.flags.z = (is_mul ? (prod == '0) : (res.lo == '0)) && zchain;
    res.flags.n = res.lo[31];
    return res;
  endfunction

  task automatic add_vec(input exec_pkg::func_t func, input exec_pkg::word_t a,
                         input exec_pkg::word_t b, input logic uf,
                         input exec_pkg::word_t lo, input exec_pkg::word_t hi,
                         input logic [3:0] cznv, input logic poke);
    vec_t v;
    v.req  = '{func: func, a: a, b: b, use_flags: uf};
    v.rsp  = '{lo: lo, hi: hi, flags: cznv};
    v.poke = poke;
    vecs.push_back(v);
  endtask

  task automatic load_table();
    add_vec(exec_pkg::FUNC_AND, 32'hF0F0F0F0, 32'hFF00FF00, 0, 32'hF000F000, 0, 4'b0010, 0);
    add_vec(exec_pkg::FUNC_OR, 32'h0F0F0000, 32'h00F0000F, 0, 32'h0FFF000F, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_XOR, 32'h12345678, 32'h12345678, 0, 32'h0, 0, 4'b0100, 0);
    add_vec(4'hA, 32'hDEADBEEF, 32'h1, 0, 32'hDEADBEEF, 0, 4'b0010, 0);
    add_vec(4'hF, 32'h0, 32'h5, 0, 32'h0, 0, 4'b0100, 0);
    add_vec(exec_pkg::FUNC_ADD, 32'h7FFFFFFF, 32'h1, 0, 32'h80000000, 0, 4'b0011, 0);
    add_vec(exec_pkg::FUNC_ADD, 32'h80000000, 32'h80000000, 0, 32'h0, 0, 4'b1101, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'h80000000, 32'h1, 0, 32'h7FFFFFFF, 0, 4'b0001, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'h0, 32'h1, 0, 32'hFFFFFFFF, 0, 4'b1010, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'h7FFFFFFF, 32'hFFFFFFFF, 0, 32'h80000000, 0, 4'b1011, 0);
    // 64-bit add 0x1_FFFFFFFF + 0x2_00000001 and then chained compares
    add_vec(exec_pkg::FUNC_ADD, 32'hFFFFFFFF, 32'h1, 0, 32'h0, 0, 4'b1100, 0);
    add_vec(exec_pkg::FUNC_ADD, 32'h1, 32'h2, 1, 32'h4, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'h1234, 32'h1234, 0, 32'h0, 0, 4'b0100, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'hABCD, 32'hABCD, 1, 32'h0, 0, 4'b0100, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'h7, 32'h3, 0, 32'h4, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_SUB, 32'h9, 32'h9, 1, 32'h0, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_ADD, 32'hFFFFFFFF, 32'h2, 0, 32'h1, 0, 4'b1000, 0);
    add_vec(exec_pkg::FUNC_OR, 32'h0, 32'h0, 1, 32'h0, 0, 4'b1000, 0);
    add_vec(exec_pkg::FUNC_SHL, 32'h80000001, 32'h0, 0, 32'h80000001, 0, 4'b0011, 0);
    add_vec(exec_pkg::FUNC_SHL, 32'h80000001, 32'h1, 0, 32'h2, 0, 4'b1001, 0);
    add_vec(exec_pkg::FUNC_SHL, 32'h3, 32'h1F, 0, 32'h80000000, 0, 4'b1010, 0);
    add_vec(exec_pkg::FUNC_SHL, 32'h1, 32'h21, 0, 32'h2, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_SRL, 32'h80000001, 32'h1, 0, 32'h40000000, 0, 4'b1001, 0);
    add_vec(exec_pkg::FUNC_SRL, 32'h80000000, 32'h1F, 0, 32'h1, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_SRA, 32'h80000001, 32'h1, 0, 32'hC0000000, 0, 4'b1010, 0);
    add_vec(exec_pkg::FUNC_SRA, 32'h80000000, 32'h1F, 0, 32'hFFFFFFFF, 0, 4'b0011, 0);
    add_vec(exec_pkg::FUNC_SRA, 32'h40000000, 32'h3F, 0, 32'h0, 0, 4'b1101, 0);
    add_vec(exec_pkg::FUNC_MUL, 32'hFFFFFFFE, 32'h3, 0, 32'hFFFFFFFA, 32'hFFFFFFFF, 4'b0010, 0);
    add_vec(exec_pkg::FUNC_MUL, 32'h7, 32'h6, 0, 32'h2A, 0, 4'b0000, 1);
    add_vec(exec_pkg::FUNC_MUL, 32'h0, 32'h80000000, 0, 32'h0, 0, 4'b0100, 0);
    add_vec(exec_pkg::FUNC_MULU, 32'hFFFFFFFF, 32'hFFFFFFFF, 0, 32'h1, 32'hFFFFFFFE, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_MULU, 32'h80000000, 32'h2, 0, 32'h0, 32'h1, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_MUL, 32'hFFFFFFFF, 32'h80000000, 0, 32'h80000000, 0, 4'b0010, 0);
    add_vec(exec_pkg::FUNC_MUL, 32'hFFFFFFFD, 32'hFFFFFFFB, 0, 32'hF, 0, 4'b0000, 0);
    add_vec(exec_pkg::FUNC_ADD, 32'h5, 32'h6, 0, 32'hB, 0, 4'b0000, 1);
  endtask

  // poke drives a second start while the stage is busy
  task automatic run_op(input exec_pkg::exec_req_t r, input logic poke,
                        input exec_pkg::exec_rsp_t exp);
    int   edges;
    logic is_mul;
    edges  = 0;
    is_mul = (r.func == exec_pkg::FUNC_MUL) || (r.func == exec_pkg::FUNC_MULU);
    req    = r;
    start  = 1'b1;
    while (!done) begin
      @(negedge clk);
      edges++;
      start = poke && (edges == 1);
      if (poke && edges == 1) begin
        req = '{func: exec_pkg::FUNC_MULU, a: ~r.a, b: ~r.b, use_flags: 1'b0};
      end
      if (!busy) begin
        abort_run("busy dropped before done");
      end
    end
    if (!is_mul && edges != 2) begin
      abort_run($sformatf("done came %0d cycles after start instead of 2", edges));
    end
    check_word("rsp.lo", rsp.lo, exp.lo);
    check_word("rsp.hi", rsp.hi, exp.hi);
    check_flags(rsp.flags, exp.flags);
    @(negedge clk);
    if (busy || done) begin
      abort_run("stage did not return to idle after done");
    end
  endtask

  initial begin
    exec_pkg::exec_req_t r;
    exec_pkg::exec_rsp_t exp;
    exec_pkg::word_t     bits;
    clk         = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    req         = '0;
    cycles      = 0;
    lfsr        = 32'd52;
    model_flags = '0;
    load_table();
    limit = (vecs.size() + N_RAND) * (exec_pkg::WIDTH + 4) + RESET_CYCLES;
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    if (busy || done) begin
      abort_run("busy or done high after reset");
    end
    check_word("rsp.lo", rsp.lo, '0);
    check_word("rsp.hi", rsp.hi, '0);
    check_flags(rsp.flags, '0);
    foreach (vecs[i]) begin
      run_op(vecs[i].req, vecs[i].poke, vecs[i].rsp);
      model_flags = vecs[i].rsp.flags;
    end
    for (int i = 0; i < N_RAND; i++) begin
      take_bits(4, bits);
      r.func = bits[3:0];
      take_bits(32, r.a);
      take_bits(32, r.b);
      take_bits(1, bits);
      r.use_flags = bits[0];
      exp = model_exec(r, model_flags);
      run_op(r, 1'b0, exp);
      model_flags = exp.flags;
    end
    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire
